//--- logic/display_pkg.sv
package display_pkg;

  // ------------------------------
  // Screen and playfield geometry
  // ------------------------------
  localparam int SCREEN_W  = 160;
  localparam int SCREEN_H  = 120;
  localparam int BRD_H     = 8;    // Left and right border
  localparam int BRD_TOP   = 24;   // Room for the score bar
  localparam int BRD_BOT   = 0;
  localparam int BLK_W     = 16;   // Power of two
  localparam int BLK_H     = 16;   // Power of two
  localparam int NUM_COL   = (SCREEN_W - 2 * BRD_H) / BLK_W;          // 9
  localparam int NUM_ROW   = (SCREEN_H - BRD_TOP - BRD_BOT) / BLK_H;  // 6
  localparam int MAP_DEPTH = NUM_COL * NUM_ROW;
  localparam int MAP_AW    = $clog2(MAP_DEPTH);

  // Pixel coordinate widths
  localparam int PIX_XW = 8;
  localparam int PIX_YW = 7;

  // Sprite sheet layout
  localparam int SPRITE_W       = 8;
  localparam int SPRITE_H       = 8;
  localparam int FRAMES_PER_DIR = 3;
  localparam int SPR_FRAMES     = 3 * FRAMES_PER_DIR;  // Left and right share a row
  localparam int SPR_DEPTH      = SPR_FRAMES * SPRITE_W * SPRITE_H;
  localparam int SPR_AW         = $clog2(SPR_DEPTH);

  // ------------------------------
  // Bus address map
  // ------------------------------
  localparam int WB_AW = 12;  // Word address
  localparam int WB_DW = 16;

  localparam logic [WB_AW-1:0] REG_PLAYER_X    = 12'h000;
  localparam logic [WB_AW-1:0] REG_PLAYER_Y    = 12'h001;
  localparam logic [WB_AW-1:0] REG_PLAYER_ANIM = 12'h002;  // Dir in [3:2], frame in [1:0]
  localparam logic [WB_AW-1:0] REG_BRD_COLOR   = 12'h003;
  localparam logic [WB_AW-1:0] REG_BG_COLOR    = 12'h004;
  localparam logic [WB_AW-1:0] MAP_BASE        = 12'h100;  // One word per tile
  localparam logic [WB_AW-1:0] SPR_BASE        = 12'h400;  // One word per sprite pixel

  // Map tile states
  typedef enum logic [1:0] {
    no_blk          = 2'd0,
    perm_blk        = 2'd1,
    destroyable_blk = 2'd2,
    bomb            = 2'd3
  } tile_state_t;

  typedef enum logic [1:0] {
    DIR_LEFT  = 2'd0,
    DIR_RIGHT = 2'd1,  // Drawn as mirrored left frames
    DIR_UP    = 2'd2,
    DIR_DOWN  = 2'd3
  } dir_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // Fixed tile colours
  localparam rgb_t COL_PERM  = rgb_t'(12'h0F0);
  localparam rgb_t COL_DESTR = rgb_t'(12'h00F);
  localparam rgb_t COL_BOMB  = rgb_t'(12'h333);

  // ------------------------------
  // Pixel stream and bus structs
  // ------------------------------
  typedef struct packed {
    logic              valid;
    logic [PIX_XW-1:0] x;
    logic [PIX_YW-1:0] y;
  } pix_req_t;

  typedef struct packed {
    logic valid;
    rgb_t rgb;
  } pix_out_t;

  // Low four bits match the anim register layout
  typedef struct packed {
    logic [PIX_XW-1:0] x;
    logic [PIX_YW-1:0] y;
    dir_t              dir;
    logic [1:0]        frame;
  } player_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage

//--- logic/display_ram.sv
module display_ram #(
  parameter type payload_t = display_pkg::rgb_t,
  // Tile states get the map depth and any other payload the sprite depth
  localparam int AW =
      ($bits(payload_t) == $bits(display_pkg::tile_state_t)) ?
      display_pkg::MAP_AW : display_pkg::SPR_AW,
  localparam int DEPTH =
      ($bits(payload_t) == $bits(display_pkg::tile_state_t)) ?
      display_pkg::MAP_DEPTH : display_pkg::SPR_DEPTH
) (
  input  logic          i_clk,
  input  logic          i_we,     // Write strobe from the bus side
  input  logic [AW-1:0] i_waddr,
  input  payload_t      i_wdata,
  input  logic [AW-1:0] i_raddr,  // Read side driven by the renderer
  output payload_t      o_rdata
);

  payload_t mem [DEPTH];  // Storage array

  // Write port
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Registered read with data one cycle after the address
  always_ff @(posedge i_clk) begin
    o_rdata <= mem[i_raddr];
  end

endmodule

//--- logic/display_regs.sv
module display_regs (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  display_pkg::wb_req_t            i_wb,
  output display_pkg::wb_rsp_t            o_wb,
  output display_pkg::player_t            o_player,
  output display_pkg::rgb_t               o_brd_color,
  output display_pkg::rgb_t               o_bg_color,
  output logic                            o_map_we,
  output logic [display_pkg::MAP_AW-1:0]  o_map_waddr,
  output display_pkg::tile_state_t        o_map_wdata,
  output logic                            o_spr_we,
  output logic [display_pkg::SPR_AW-1:0]  o_spr_waddr,
  output display_pkg::rgb_t               o_spr_wdata
);
  import display_pkg::*;

  localparam int TILE_BITS = $bits(tile_state_t);
  localparam int RGB_BITS  = $bits(rgb_t);

  logic             ack_q;     // Single-cycle ack
  logic [WB_DW-1:0] rdat_q;    // Read data held with ack
  logic             req;       // Fresh request this cycle
  logic             map_hit;
  logic             spr_hit;
  logic [WB_DW-1:0] rd_mux;
  player_t          player_q;
  rgb_t             brd_q;
  rgb_t             bg_q;

  // ------------------------------
  // Address decode and handshake
  // ------------------------------
  // Master holds the request through the ack cycle so mask it there
  assign req = i_wb.cyc && i_wb.stb && !ack_q;

  assign map_hit = (i_wb.adr >= MAP_BASE) &&
                   (i_wb.adr < MAP_BASE + WB_AW'(MAP_DEPTH));
  assign spr_hit = (i_wb.adr >= SPR_BASE) &&
                   (i_wb.adr < SPR_BASE + WB_AW'(SPR_DEPTH));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;  // One cycle after the request is seen
    end
  end

  // ------------------------------
  // Player and colour registers
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      player_q <= '0;
      brd_q    <= '0;
      bg_q     <= '0;
    end else if (req && i_wb.we) begin
      case (i_wb.adr)
        REG_PLAYER_X: player_q.x <= i_wb.dat[PIX_XW-1:0];
        REG_PLAYER_Y: player_q.y <= i_wb.dat[PIX_YW-1:0];
        REG_PLAYER_ANIM: begin
          player_q.dir   <= dir_t'(i_wb.dat[3:2]);
          player_q.frame <= i_wb.dat[1:0];
        end
        REG_BRD_COLOR: brd_q <= rgb_t'(i_wb.dat[RGB_BITS-1:0]);
        REG_BG_COLOR:  bg_q  <= rgb_t'(i_wb.dat[RGB_BITS-1:0]);
        default: ;  // Memory windows handled below
      endcase
    end
  end

  // Read mux where the memory windows read back as zero
  always_comb begin
    rd_mux = '0;
    case (i_wb.adr)
      REG_PLAYER_X:    rd_mux = WB_DW'(player_q.x);
      REG_PLAYER_Y:    rd_mux = WB_DW'(player_q.y);
      REG_PLAYER_ANIM: rd_mux = WB_DW'({player_q.dir, player_q.frame});
      REG_BRD_COLOR:   rd_mux = WB_DW'(brd_q);
      REG_BG_COLOR:    rd_mux = WB_DW'(bg_q);
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (req) begin
      rdat_q <= rd_mux;  // Valid together with ack
    end
  end

  // ------------------------------
  // Memory write strobes
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_map_we <= 1'b0;
      o_spr_we <= 1'b0;
    end else begin
      o_map_we <= req && i_wb.we && map_hit;  // Lines up with ack
      o_spr_we <= req && i_wb.we && spr_hit;
    end
  end

  // Offsets from the window bases
  always_ff @(posedge i_clk) begin
    if (req) begin
      o_map_waddr <= MAP_AW'(i_wb.adr - MAP_BASE);
      o_map_wdata <= tile_state_t'(i_wb.dat[TILE_BITS-1:0]);
      o_spr_waddr <= SPR_AW'(i_wb.adr - SPR_BASE);
      o_spr_wdata <= rgb_t'(i_wb.dat[RGB_BITS-1:0]);
    end
  end

  assign o_wb        = '{ack: ack_q, dat: rdat_q};
  assign o_player    = player_q;
  assign o_brd_color = brd_q;
  assign o_bg_color  = bg_q;

endmodule

//--- logic/tile_renderer.sv
module tile_renderer (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  display_pkg::pix_req_t          i_pix,
  input  display_pkg::player_t           i_player,
  input  display_pkg::rgb_t              i_brd_color,
  input  display_pkg::rgb_t              i_bg_color,
  output logic [display_pkg::MAP_AW-1:0] o_map_raddr,
  input  display_pkg::tile_state_t       i_map_rdata,
  output logic [display_pkg::SPR_AW-1:0] o_spr_raddr,
  input  display_pkg::rgb_t              i_spr_rdata,
  output display_pkg::pix_out_t          o_pix
);
  import display_pkg::*;

  localparam int LX_W       = $clog2(SPRITE_W);
  localparam int LY_W       = $clog2(SPRITE_H);
  localparam int FRM_W      = $clog2(SPR_FRAMES);
  localparam int COL_W      = $clog2(NUM_COL);
  localparam int ROW_W      = $clog2(NUM_ROW);
  localparam int BLK_W_LOG2 = $clog2(BLK_W);
  localparam int BLK_H_LOG2 = $clog2(BLK_H);
  localparam int FRM_PIX    = SPRITE_W * SPRITE_H;  // Pixels per frame

  logic              out_of_map;
  logic              in_sprite;
  logic [LX_W-1:0]   local_x;
  logic [LY_W-1:0]   local_y;
  logic [LX_W-1:0]   rom_x;      // Column within the stored frame
  logic [FRM_W-1:0]  frame_idx;
  logic [PIX_XW-1:0] map_x;
  logic [PIX_YW-1:0] map_y;
  logic [COL_W-1:0]  col;
  logic [ROW_W-1:0]  row;
  logic              s1_valid;
  logic              s1_border;
  logic              s1_sprite;
  rgb_t              tile_rgb;
  rgb_t              pix_rgb;
  logic              out_valid_q;
  rgb_t              out_rgb_q;

  // ------------------------------
  // Stage 1 classification
  // ------------------------------
  always_comb begin
    out_of_map = (i_pix.x < BRD_H) ||
                 (i_pix.x >= SCREEN_W - BRD_H) ||
                 (i_pix.y < BRD_TOP) ||
                 (i_pix.y >= SCREEN_H - BRD_BOT);
  end

  // Sprite box test with 32-bit sums that cannot wrap
  always_comb begin
    in_sprite = (i_pix.x >= i_player.x) && (i_pix.x < i_player.x + SPRITE_W) &&
                (i_pix.y >= i_player.y) && (i_pix.y < i_player.y + SPRITE_H);
    local_x   = '0;
    local_y   = '0;
    if (in_sprite) begin
      local_x = LX_W'(i_pix.x - i_player.x);
      local_y = LY_W'(i_pix.y - i_player.y);
    end
  end

  always_comb begin
    case (i_player.dir)
      DIR_RIGHT: rom_x = LX_W'(SPRITE_W - 1) - local_x;  // Mirrored
      default:   rom_x = local_x;
    endcase
  end

  // Frame rows in the sheet
  always_comb begin
    case (i_player.dir)
      DIR_LEFT,
      DIR_RIGHT: frame_idx = FRM_W'(i_player.frame);                         // 0..2
      DIR_UP:    frame_idx = FRM_W'(FRAMES_PER_DIR) + FRM_W'(i_player.frame);  // 3..5
      DIR_DOWN:  frame_idx = FRM_W'(2 * FRAMES_PER_DIR) + FRM_W'(i_player.frame);
      default:   frame_idx = '0;
    endcase
  end

  always_comb begin
    o_spr_raddr = '0;
    if (in_sprite) begin
      o_spr_raddr = SPR_AW'(frame_idx * FRM_PIX + local_y * SPRITE_W + rom_x);
    end
  end

  // Map address with the border offset taken out
  always_comb begin
    map_x       = i_pix.x - PIX_XW'(BRD_H);
    map_y       = i_pix.y - PIX_YW'(BRD_TOP);
    col         = COL_W'(map_x >> BLK_W_LOG2);
    row         = ROW_W'(map_y >> BLK_H_LOG2);
    o_map_raddr = out_of_map ? '0 : MAP_AW'(row * NUM_COL + col);
  end

  // Flags travel alongside the RAM reads
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_valid  <= 1'b0;
      s1_border <= 1'b0;
      s1_sprite <= 1'b0;
    end else begin
      s1_valid  <= i_pix.valid;
      s1_border <= out_of_map;
      s1_sprite <= in_sprite;
    end
  end

  // ------------------------------
  // Stage 2 colour select
  // ------------------------------
  always_comb begin
    tile_rgb = i_bg_color;
    case (i_map_rdata)
      no_blk:          tile_rgb = i_bg_color;
      perm_blk:        tile_rgb = COL_PERM;
      destroyable_blk: tile_rgb = COL_DESTR;
      bomb:            tile_rgb = COL_BOMB;
      default:         tile_rgb = i_bg_color;
    endcase
  end

  // Border over sprite over tile
  always_comb begin
    if (s1_border) begin
      pix_rgb = i_brd_color;
    end else if (s1_sprite) begin
      pix_rgb = i_spr_rdata;
    end else begin
      pix_rgb = tile_rgb;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    out_rgb_q <= pix_rgb;  // Colour payload
  end

  assign o_pix = '{valid: out_valid_q, rgb: out_rgb_q};

endmodule

//--- logic/game_display.sv
module game_display (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  display_pkg::wb_req_t  i_wb,
  output display_pkg::wb_rsp_t  o_wb,
  input  display_pkg::pix_req_t i_pix,
  output display_pkg::pix_out_t o_pix
);
  import display_pkg::*;

  // ------------------------------
  // Interconnect
  // ------------------------------
  player_t           player;
  rgb_t              brd_color;
  rgb_t              bg_color;
  logic              map_we;
  logic [MAP_AW-1:0] map_waddr;
  tile_state_t       map_wdata;
  logic [MAP_AW-1:0] map_raddr;
  tile_state_t       map_rdata;
  logic              spr_we;
  logic [SPR_AW-1:0] spr_waddr;
  rgb_t              spr_wdata;
  logic [SPR_AW-1:0] spr_raddr;
  rgb_t              spr_rdata;

  // Bus side register block
  display_regs u_regs (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wb        (i_wb),
    .o_wb        (o_wb),
    .o_player    (player),
    .o_brd_color (brd_color),
    .o_bg_color  (bg_color),
    .o_map_we    (map_we),
    .o_map_waddr (map_waddr),
    .o_map_wdata (map_wdata),
    .o_spr_we    (spr_we),
    .o_spr_waddr (spr_waddr),
    .o_spr_wdata (spr_wdata)
  );

  // Tile map of 54 states
  display_ram #(.payload_t(tile_state_t)) u_map_ram (
    .i_clk   (i_clk),
    .i_we    (map_we),
    .i_waddr (map_waddr),
    .i_wdata (map_wdata),
    .i_raddr (map_raddr),
    .o_rdata (map_rdata)
  );

  // Sprite sheet of nine 8x8 frames
  display_ram #(.payload_t(rgb_t)) u_spr_ram (
    .i_clk   (i_clk),
    .i_we    (spr_we),
    .i_waddr (spr_waddr),
    .i_wdata (spr_wdata),
    .i_raddr (spr_raddr),
    .o_rdata (spr_rdata)
  );

  tile_renderer u_renderer (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_pix       (i_pix),
    .i_player    (player),
    .i_brd_color (brd_color),
    .i_bg_color  (bg_color),
    .o_map_raddr (map_raddr),
    .i_map_rdata (map_rdata),
    .o_spr_raddr (spr_raddr),
    .i_spr_rdata (spr_rdata),
    .o_pix       (o_pix)
  );

endmodule

//--- verif/tb_clock.sv
module tb_clock (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 4;  // 8 ns period

  initial begin
    o_clk = 1'b0;
    forever begin
      #HALF_PERIOD o_clk = ~o_clk;
    end
  end

endmodule

//--- verif/tb_game_display.sv
module tb_game_display;
  timeunit 1ns;
  timeprecision 100ps;
  import display_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int BOX_PIX    = SPRITE_W * SPRITE_H;
  // Bus cycles plus pixels in each test
  localparam int OPS_T1     = 17;
  localparam int OPS_T2     = 1 + 32;
  localparam int OPS_T3     = 3 + 2 * MAP_DEPTH;
  localparam int OPS_T4     = SPR_DEPTH + 2 + 12 * (BOX_PIX + 2);
  localparam int OPS_T5     = 7 + 2 * BOX_PIX + 1;
  localparam int WD_CYCLES  = 10 * (OPS_T1 + OPS_T2 + OPS_T3 + OPS_T4 + OPS_T5) + 500;

  logic     clk;
  logic     rst;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  pix_req_t pix_req;
  pix_out_t pix_out;

  // ------------------------------
  // Reference model state
  // ------------------------------
  tile_state_t ref_map [MAP_DEPTH];
  rgb_t        ref_spr [SPR_DEPTH];
  player_t     ref_player;
  rgb_t        ref_brd;
  rgb_t        ref_bg;

  int   seed;
  int   cyc_cnt = 0;  // Rising edges seen so far
  logic mon_en;
  int   due_q [$];    // Cycle at which each pending pixel shows up
  rgb_t rgb_q [$];    // Expected colours in request order

  tb_clock u_clock (
    .o_clk (clk)
  );

  game_display i_game_display (
    .i_clk (clk),
    .i_rst (rst),
    .i_wb  (wb_req),
    .o_wb  (wb_rsp),
    .i_pix (pix_req),
    .o_pix (pix_out)
  );

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Mirror of a bus write into the model
  function automatic void model_write(logic [11:0] adr, logic [15:0] dat);
    if (adr >= MAP_BASE && adr < MAP_BASE + MAP_DEPTH) begin
      ref_map[adr - MAP_BASE] = tile_state_t'(dat[1:0]);
    end else if (adr >= SPR_BASE && adr < SPR_BASE + SPR_DEPTH) begin
      ref_spr[adr - SPR_BASE] = rgb_t'(dat[11:0]);
    end else begin
      case (adr)
        REG_PLAYER_X:    ref_player.x = dat[7:0];
        REG_PLAYER_Y:    ref_player.y = dat[6:0];
        REG_PLAYER_ANIM: begin
          ref_player.dir   = dir_t'(dat[3:2]);
          ref_player.frame = dat[1:0];
        end
        REG_BRD_COLOR:   ref_brd = rgb_t'(dat[11:0]);
        REG_BG_COLOR:    ref_bg = rgb_t'(dat[11:0]);
        default: ;
      endcase
    end
  endfunction

  function automatic logic [15:0] reg_value(logic [11:0] adr);
    case (adr)
      REG_PLAYER_X:    return 16'(ref_player.x);
      REG_PLAYER_Y:    return 16'(ref_player.y);
      REG_PLAYER_ANIM: return 16'({ref_player.dir, ref_player.frame});
      REG_BRD_COLOR:   return 16'(ref_brd);
      REG_BG_COLOR:    return 16'(ref_bg);
      default:         return 16'h0000;  // Unmapped and memory windows
    endcase
  endfunction

  // Border, then sprite, then tile
  function automatic rgb_t model_color(int x, int y);
    int px;
    int py;
    int lx;
    int ly;
    int fi;
    tile_state_t ts;
    px = ref_player.x;
    py = ref_player.y;
    if (x < BRD_H || x >= SCREEN_W - BRD_H || y < BRD_TOP || y >= SCREEN_H - BRD_BOT) begin
      return ref_brd;
    end
    if (x >= px && x < px + SPRITE_W && y >= py && y < py + SPRITE_H) begin
      lx = x - px;
      ly = y - py;
      if (ref_player.dir == DIR_RIGHT) begin
        lx = SPRITE_W - 1 - lx;  // Left frames drawn mirrored
      end
      case (ref_player.dir)
        DIR_UP:   fi = FRAMES_PER_DIR + ref_player.frame;
        DIR_DOWN: fi = 2 * FRAMES_PER_DIR + ref_player.frame;
        default:  fi = ref_player.frame;
      endcase
      return ref_spr[fi * BOX_PIX + ly * SPRITE_W + lx];
    end
    ts = ref_map[((y - BRD_TOP) / BLK_H) * NUM_COL + (x - BRD_H) / BLK_W];
    case (ts)
      perm_blk:        return COL_PERM;
      destroyable_blk: return COL_DESTR;
      bomb:            return COL_BOMB;
      default:         return ref_bg;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ------------------------------
  // Bus and pixel drivers
  // ------------------------------
  task automatic wait_ack();
    do begin
      @(negedge clk);
    end while (!wb_rsp.ack);
  endtask

  // Drop the request and expect ack back low one cycle later
  task automatic end_cycle();
    @(posedge clk);
    wb_req <= '0;  // Idle for at least one cycle
    @(negedge clk);
    check_eq("o_wb.ack", wb_rsp.ack, 1'b0);
  endtask

  task automatic wb_write(input logic [11:0] adr, input logic [15:0] dat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    wait_ack();
    model_write(adr, dat);
    end_cycle();
  endtask

  task automatic wb_read(input logic [11:0] adr, output logic [15:0] dat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 16'h0};
    wait_ack();
    dat = wb_rsp.dat;  // Held with ack
    end_cycle();
  endtask

  task automatic send_pixel(input int xpos, input int ypos);
    @(posedge clk);
    pix_req <= '{valid: 1'b1, x: 8'(xpos), y: 7'(ypos)};
    due_q.push_back(cyc_cnt + 3);  // Two cycles of latency
    rgb_q.push_back(model_color(xpos, ypos));
  endtask

  task automatic drain_pixels();
    @(posedge clk);
    pix_req <= '0;
    while (due_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic send_box(input int bx, input int by);
    for (int ly = 0; ly < SPRITE_H; ly++) begin
      for (int lx = 0; lx < SPRITE_W; lx++) begin
        send_pixel(bx + lx, by + ly);
      end
    end
  endtask

  // Output checker expecting valid only on the due cycle
  always @(negedge clk) begin
    if (mon_en) begin
      if (due_q.size() != 0 && due_q[0] == cyc_cnt) begin
        check_eq("o_pix.valid", pix_out.valid, 1'b1);
        check_eq("o_pix.rgb", pix_out.rgb, rgb_q[0]);
        void'(due_q.pop_front());
        void'(rgb_q.pop_front());
      end else begin
        check_eq("o_pix.valid", pix_out.valid, 1'b0);
      end
    end
  end

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_and_registers();
    logic [15:0] rd;
    repeat (4) begin
      @(negedge clk);
      check_eq("o_pix.valid", pix_out.valid, 1'b0);
      check_eq("o_wb.ack", wb_rsp.ack, 1'b0);
    end
    for (int a = 0; a < 5; a++) begin
      wb_read(12'(a), rd);
      check_eq($sformatf("reset reg 0x%0h", a), rd, 16'h0);
    end
    for (int a = 0; a < 5; a++) begin
      wb_write(12'(a), 16'(rand_below(65536)));  // Upper bits beyond each field dropped
    end
    for (int a = 0; a < 5; a++) begin
      wb_read(12'(a), rd);
      check_eq($sformatf("reg 0x%0h", a), rd, reg_value(12'(a)));
    end
    wb_read(12'h005, rd);
    check_eq("unmapped read", rd, 16'h0);
    wb_read(MAP_BASE, rd);
    check_eq("map window read", rd, 16'h0);
  endtask

  task automatic border_pixels();
    wb_write(REG_BRD_COLOR, 16'(rand_below(4096)));
    for (int i = 0; i < 8; i++) begin
      send_pixel(i, BRD_TOP + rand_below(SCREEN_H - BRD_TOP));  // Left
      drain_pixels();
      send_pixel(SCREEN_W - BRD_H + i, rand_below(SCREEN_H));   // Right
      drain_pixels();
      send_pixel(rand_below(SCREEN_W), 3 * i);                  // Top
      drain_pixels();
      send_pixel(rand_below(SCREEN_W), SCREEN_H - BRD_BOT + i); // Below the last row
      drain_pixels();
    end
  endtask

  task automatic tile_map_pixels();
    wb_write(REG_PLAYER_X, 16'h0);  // Sprite parked in the corner border
    wb_write(REG_PLAYER_Y, 16'h0);
    wb_write(REG_BG_COLOR, 16'(rand_below(4096)));
    for (int t = 0; t < MAP_DEPTH; t++) begin
      wb_write(MAP_BASE + 12'(t), 16'(rand_below(4)));
    end
    // One random point per tile, back to back
    for (int r = 0; r < NUM_ROW; r++) begin
      for (int c = 0; c < NUM_COL; c++) begin
        send_pixel(BRD_H + c * BLK_W + rand_below(BLK_W),
                   BRD_TOP + r * BLK_H + rand_below(BLK_H));
      end
    end
    drain_pixels();
  endtask

  task automatic sprite_frames();
    int px;
    int py;
    px = 40;
    py = 50;
    for (int a = 0; a < SPR_DEPTH; a++) begin
      wb_write(SPR_BASE + 12'(a), 16'(rand_below(4096)));
    end
    wb_write(REG_PLAYER_X, 16'(px));
    wb_write(REG_PLAYER_Y, 16'(py));
    for (int d = 0; d < 4; d++) begin
      for (int f = 0; f < FRAMES_PER_DIR; f++) begin
        wb_write(REG_PLAYER_ANIM, 16'(d * 4 + f));  // Dir in [3:2]
        send_box(px, py);
        send_pixel(px + SPRITE_W, py);  // Just right of the box
        drain_pixels();
      end
    end
  endtask

  task automatic layer_priority();
    // Box across the left border with a bomb under its map part
    wb_write(MAP_BASE + 12'(2 * NUM_COL), 16'(bomb));
    wb_write(REG_PLAYER_X, 16'd2);
    wb_write(REG_PLAYER_Y, 16'd60);
    wb_write(REG_PLAYER_ANIM, 16'(DIR_DOWN * 4 + 1));
    send_box(2, 60);
    drain_pixels();
    // Box fully inside one bomb tile
    wb_write(MAP_BASE + 12'(NUM_COL + 3), 16'(bomb));
    wb_write(REG_PLAYER_X, 16'd60);
    wb_write(REG_PLAYER_Y, 16'd44);
    send_box(60, 44);
    send_pixel(57, 41);  // Same tile outside the box
    drain_pixels();
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    seed       = 48525;
    mon_en     = 1'b0;
    rst        = 1'b1;
    wb_req     = '0;
    pix_req    = '0;
    ref_player = '0;
    ref_brd    = '0;
    ref_bg     = '0;
    foreach (ref_map[i]) begin
      ref_map[i] = no_blk;
    end
    foreach (ref_spr[i]) begin
      ref_spr[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst    <= 1'b0;
    mon_en <= 1'b1;
    reset_and_registers();
    border_pixels();
    tile_map_pixels();
    sprite_frames();
    layer_priority();
    $display("test passed");
    $finish;
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the run did not complete", WD_CYCLES);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- game_display.f
logic/display_pkg.sv
logic/display_ram.sv
logic/display_regs.sv
logic/tile_renderer.sv
logic/game_display.sv
verif/tb_clock.sv
verif/tb_game_display.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_game_display
FILELIST   ?= game_display.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The simulator exits non-zero on a fatal check, so the log decides
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "test passed" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
